/* source/isaPkg.sv */
//##########################################################
// ISA definitions for the branch path
// opcode encodings and data and address widths of the core
//##########################################################
`default_nettype none

package isaPkg;

    // operand and address widths
    localparam int dataWidth = 32;
    localparam int addrWidth = 32;
    localparam int opWidth   = 4;

    // opNop doubles as the empty-slot marker
    typedef enum logic [opWidth-1:0] {
        opNop  = 0,
        opBeq  = 1,
        opBne  = 2,
        opBlt  = 3,
        opBge  = 4,
        opBltu = 5,
        opBgeu = 6,
        opJal  = 7,
        opJalr = 8
    } branchOp;

endpackage

`default_nettype wire

/* source/rsPkg.sv */
//##########################################################
// Reservation station definitions
// tag width, resolved-tag value and station defaults
//##########################################################
`default_nettype none

package rsPkg;

    // reorder-buffer tag width
    localparam int tagWidth = 5;

    // real tags are never zero, so zero means "value present"
    localparam logic [tagWidth-1:0] tagFree = '0;

    // cleared operand value
    localparam logic [31:0] dataFree = '0;

    // slot count when the top level does not override it
    localparam int defaultRsSize = 4;

endpackage

`default_nettype wire

/* source/branchRsCtrl.sv */
//##########################################################
// Branch reservation station control
// picks dispatch and issue slots, tracks occupancy
//##########################################################
`default_nettype none
`timescale 1ns/100ps

module branchRsCtrl #(
    parameter int rsSize = rsPkg::defaultRsSize
) (
    input  logic              clk,
    input  logic              rst,
    input  logic              dispatchEn,
    input  logic [rsSize-1:0] slotEmpty,
    input  logic [rsSize-1:0] slotReady,
    output logic [rsSize-1:0] allocOneHot,
    output logic [rsSize-1:0] issueOneHot,
    output logic              issueEn,
    output logic [rsSize-1:0] freeSlots
);

    localparam int countWidth = $clog2(rsSize + 1);

    logic [countWidth-1:0] occupiedCount;

    // isolate lowest set bit
    function automatic logic [rsSize-1:0] lowestSet(input logic [rsSize-1:0] vec);
        logic [rsSize-1:0] twos;
        twos = ~vec + rsSize'(1);
        return vec & twos;
    endfunction

    // lowest empty slot takes the new branch
    always_comb begin
        if (dispatchEn) begin
            allocOneHot = lowestSet(slotEmpty);
        end else begin
            allocOneHot = '0;
        end
    end

    // lower index wins when several are ready
    assign issueOneHot = lowestSet(slotReady);
    assign issueEn     = |slotReady;

    assign freeSlots = slotEmpty;

    // occupancy, one in and one out per cycle at most
    always_ff @(posedge clk) begin
        if (rst) begin
            occupiedCount <= '0;
        end else begin
            occupiedCount <= occupiedCount
                           + countWidth'(|allocOneHot)
                           - countWidth'(|issueOneHot);
        end
    end

endmodule

`default_nettype wire

/* source/branchRsEntries.sv */
//##########################################################
// Branch reservation station slots
// operand storage, CDB wakeup and issue readout
//##########################################################
`default_nettype none
`timescale 1ns/100ps

module branchRsEntries #(
    parameter int rsSize = rsPkg::defaultRsSize
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic [rsSize-1:0]             allocOneHot,
    input  logic [rsSize-1:0]             issueOneHot,
    input  isaPkg::branchOp               dispatchOp,
    input  logic [isaPkg::dataWidth-1:0]  dispatchDataO,
    input  logic [isaPkg::dataWidth-1:0]  dispatchDataT,
    input  logic [isaPkg::dataWidth-1:0]  dispatchImm,
    input  logic [isaPkg::addrWidth-1:0]  dispatchPc,
    input  logic [rsPkg::tagWidth-1:0]    dispatchTagO,
    input  logic [rsPkg::tagWidth-1:0]    dispatchTagT,
    input  logic [rsPkg::tagWidth-1:0]    dispatchDest,
    input  logic                          aluWrtEn,
    input  logic                          lsWrtEn,
    input  logic [rsPkg::tagWidth-1:0]    aluTag,
    input  logic [rsPkg::tagWidth-1:0]    lsTag,
    input  logic [isaPkg::dataWidth-1:0]  aluData,
    input  logic [isaPkg::dataWidth-1:0]  lsData,
    output logic [rsSize-1:0]             slotEmpty,
    output logic [rsSize-1:0]             slotReady,
    output isaPkg::branchOp               issueOp,
    output logic [isaPkg::dataWidth-1:0]  issueDataO,
    output logic [isaPkg::dataWidth-1:0]  issueDataT,
    output logic [isaPkg::dataWidth-1:0]  issueImm,
    output logic [isaPkg::addrWidth-1:0]  issuePc,
    output logic [rsPkg::tagWidth-1:0]    issueDest
);

    localparam int tw = rsPkg::tagWidth;
    localparam int dw = isaPkg::dataWidth;

    isaPkg::branchOp          slotOp    [rsSize];
    logic [dw-1:0]            slotDataO [rsSize];
    logic [dw-1:0]            slotDataT [rsSize];
    logic [tw-1:0]            slotTagO  [rsSize];
    logic [tw-1:0]            slotTagT  [rsSize];
    logic [dw-1:0]            slotImm   [rsSize];
    logic [isaPkg::addrWidth-1:0] slotPc [rsSize];
    logic [tw-1:0]            slotDest  [rsSize];

    logic [dw-1:0]            nextDataO [rsSize];
    logic [dw-1:0]            nextDataT [rsSize];
    logic [tw-1:0]            nextTagO  [rsSize];
    logic [tw-1:0]            nextTagT  [rsSize];

    // wake one operand from either bus into {tag, data}
    function automatic logic [tw+dw-1:0] wake(
        input logic [tw-1:0] tag,
        input logic [dw-1:0] data,
        input logic          aEn,
        input logic [tw-1:0] aTag,
        input logic [dw-1:0] aData,
        input logic          lEn,
        input logic [tw-1:0] lTag,
        input logic [dw-1:0] lData
    );
        if (tag == rsPkg::tagFree) begin
            return {tag, data};
        end else if (aEn && tag == aTag) begin
            return {rsPkg::tagFree, aData};
        end else if (lEn && tag == lTag) begin
            return {rsPkg::tagFree, lData};
        end
        return {tag, data};
    endfunction

    // empty and ready flags straight from the slot registers
    always_comb begin
        for (int i = 0; i < rsSize; i++) begin
            slotEmpty[i] = slotOp[i] == isaPkg::opNop;
            slotReady[i] = slotOp[i] != isaPkg::opNop && slotTagO[i] == rsPkg::tagFree
                           && slotTagT[i] == rsPkg::tagFree;
        end
    end

    // new entry sees the same-edge broadcast too
    always_comb begin
        for (int i = 0; i < rsSize; i++) begin
            {nextTagO[i], nextDataO[i]} = wake(
                allocOneHot[i] ? dispatchTagO : slotTagO[i],
                allocOneHot[i] ? dispatchDataO : slotDataO[i],
                aluWrtEn, aluTag, aluData, lsWrtEn, lsTag, lsData);
            {nextTagT[i], nextDataT[i]} = wake(
                allocOneHot[i] ? dispatchTagT : slotTagT[i],
                allocOneHot[i] ? dispatchDataT : slotDataT[i],
                aluWrtEn, aluTag, aluData, lsWrtEn, lsTag, lsData);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < rsSize; i++) begin
                slotOp[i]    <= isaPkg::opNop;
                slotTagO[i]  <= rsPkg::tagFree;
                slotTagT[i]  <= rsPkg::tagFree;
                slotDataO[i] <= rsPkg::dataFree;
                slotDataT[i] <= rsPkg::dataFree;
            end
        end else begin
            for (int i = 0; i < rsSize; i++) begin
                if (allocOneHot[i]) begin
                    slotOp[i] <= dispatchOp;
                end else if (issueOneHot[i]) begin
                    slotOp[i] <= isaPkg::opNop;
                end
                if (allocOneHot[i] || !slotEmpty[i]) begin
                    slotTagO[i]  <= nextTagO[i];
                    slotTagT[i]  <= nextTagT[i];
                    slotDataO[i] <= nextDataO[i];
                    slotDataT[i] <= nextDataT[i];
                end
            end
        end
    end

    // payload fields only change on dispatch
    always_ff @(posedge clk) begin
        for (int i = 0; i < rsSize; i++) begin
            if (allocOneHot[i]) begin
                slotImm[i]  <= dispatchImm;
                slotPc[i]   <= dispatchPc;
                slotDest[i] <= dispatchDest;
            end
        end
    end

    // readout of the one selected slot
    always_comb begin
        issueOp    = isaPkg::opNop;
        issueDataO = '0;
        issueDataT = '0;
        issueImm   = '0;
        issuePc    = '0;
        issueDest  = '0;
        for (int i = 0; i < rsSize; i++) begin
            if (issueOneHot[i]) begin
                issueOp    = slotOp[i];
                issueDataO = slotDataO[i];
                issueDataT = slotDataT[i];
                issueImm   = slotImm[i];
                issuePc    = slotPc[i];
                issueDest  = slotDest[i];
            end
        end
    end

endmodule

`default_nettype wire

/* source/branchExec.sv */
//##########################################################
// Branch execution unit
// registered condition, target and link computation
//##########################################################
`default_nettype none
`timescale 1ns/100ps

module branchExec (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          issueEn,
    input  isaPkg::branchOp               issueOp,
    input  logic [isaPkg::dataWidth-1:0]  issueDataO,
    input  logic [isaPkg::dataWidth-1:0]  issueDataT,
    input  logic [isaPkg::dataWidth-1:0]  issueImm,
    input  logic [isaPkg::addrWidth-1:0]  issuePc,
    input  logic [rsPkg::tagWidth-1:0]    issueDest,
    output logic                          resultValid,
    output logic                          resultTaken,
    output logic [rsPkg::tagWidth-1:0]    resultTag,
    output logic [isaPkg::addrWidth-1:0]  resultTarget,
    output logic [isaPkg::addrWidth-1:0]  resultLink
);

    logic                         taken;
    logic [isaPkg::addrWidth-1:0] target;
    logic [isaPkg::addrWidth-1:0] jalrSum;

    assign jalrSum = issueDataO + issueImm;

    always_comb begin
        target = issuePc + issueImm;
        case (issueOp)
            isaPkg::opBeq:  taken = issueDataO == issueDataT;
            isaPkg::opBne:  taken = issueDataO != issueDataT;
            isaPkg::opBlt:  taken = $signed(issueDataO) < $signed(issueDataT);
            isaPkg::opBge:  taken = $signed(issueDataO) >= $signed(issueDataT);
            isaPkg::opBltu: taken = issueDataO < issueDataT;
            isaPkg::opBgeu: taken = issueDataO >= issueDataT;
            isaPkg::opJal:  taken = 1'b1;
            isaPkg::opJalr: begin
                taken  = 1'b1;
                // register-relative, low bit dropped
                target = {jalrSum[isaPkg::addrWidth-1:1], 1'b0};
            end
            default:        taken = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resultValid <= 1'b0;
        end else begin
            resultValid <= issueEn;
        end
    end

    always_ff @(posedge clk) begin
        if (issueEn) begin
            resultTaken  <= taken;
            resultTag    <= issueDest;
            resultTarget <= target;
            resultLink   <= issuePc + isaPkg::addrWidth'(4);
        end
    end

endmodule

`default_nettype wire

/* source/branchUnit.sv */
//##########################################################
// Branch issue path top level
// reservation station control, slots and execution
//##########################################################
`default_nettype none
`timescale 1ns/100ps

module branchUnit #(
    parameter int rsSize = rsPkg::defaultRsSize
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          dispatchEn,
    input  isaPkg::branchOp               dispatchOp,
    input  logic [isaPkg::dataWidth-1:0]  dispatchDataO,
    input  logic [isaPkg::dataWidth-1:0]  dispatchDataT,
    input  logic [rsPkg::tagWidth-1:0]    dispatchTagO,
    input  logic [rsPkg::tagWidth-1:0]    dispatchTagT,
    input  logic [isaPkg::dataWidth-1:0]  dispatchImm,
    input  logic [isaPkg::addrWidth-1:0]  dispatchPc,
    input  logic [rsPkg::tagWidth-1:0]    dispatchDest,
    input  logic                          aluWrtEn,
    input  logic [rsPkg::tagWidth-1:0]    aluTag,
    input  logic [isaPkg::dataWidth-1:0]  aluData,
    input  logic                          lsWrtEn,
    input  logic [rsPkg::tagWidth-1:0]    lsTag,
    input  logic [isaPkg::dataWidth-1:0]  lsData,
    output logic [rsSize-1:0]             freeSlots,
    output logic                          resultValid,
    output logic [rsPkg::tagWidth-1:0]    resultTag,
    output logic                          resultTaken,
    output logic [isaPkg::addrWidth-1:0]  resultTarget,
    output logic [isaPkg::addrWidth-1:0]  resultLink
);

    logic [rsSize-1:0]             slotEmpty;
    logic [rsSize-1:0]             slotReady;
    logic [rsSize-1:0]             allocOneHot;
    logic [rsSize-1:0]             issueOneHot;
    logic                          issueEn;
    isaPkg::branchOp               issueOp;
    logic [isaPkg::dataWidth-1:0]  issueDataO;
    logic [isaPkg::dataWidth-1:0]  issueDataT;
    logic [isaPkg::dataWidth-1:0]  issueImm;
    logic [isaPkg::addrWidth-1:0]  issuePc;
    logic [rsPkg::tagWidth-1:0]    issueDest;

    branchRsCtrl #(.rsSize(rsSize)) ctrl (
        .clk, .rst, .dispatchEn, .slotEmpty, .slotReady,
        .allocOneHot, .issueOneHot, .issueEn, .freeSlots
    );

    branchRsEntries #(.rsSize(rsSize)) entries (
        .clk, .rst, .allocOneHot, .issueOneHot,
        .dispatchOp, .dispatchDataO, .dispatchDataT, .dispatchImm, .dispatchPc,
        .dispatchTagO, .dispatchTagT, .dispatchDest,
        .aluWrtEn, .lsWrtEn, .aluTag, .lsTag, .aluData, .lsData,
        .slotEmpty, .slotReady,
        .issueOp, .issueDataO, .issueDataT, .issueImm, .issuePc, .issueDest
    );

    branchExec exec (
        .clk, .rst, .issueEn, .issueOp, .issueDataO, .issueDataT,
        .issueImm, .issuePc, .issueDest,
        .resultValid, .resultTaken, .resultTag, .resultTarget, .resultLink
    );

endmodule

`default_nettype wire

/* tests/branchUnit_assertions.sv */
//##########################################################
// Bound checks on the branch reservation station control
//##########################################################
`default_nettype none
`timescale 1ns/100ps

module rsCtrlChecks #(
    parameter int rsSize = rsPkg::defaultRsSize
) (
    input logic                          clk,
    input logic                          rst,
    input logic [rsSize-1:0]             slotEmpty,
    input logic [rsSize-1:0]             slotReady,
    input logic [rsSize-1:0]             allocOneHot,
    input logic [rsSize-1:0]             issueOneHot,
    input logic [$clog2(rsSize + 1)-1:0] occupiedCount
);

    // at most one slot leaves per cycle
    issueSingle: assert property (@(posedge clk) disable iff (rst)
        $onehot0(issueOneHot))
        else $error("issueOneHot selects more than one slot");

    issueFromReady: assert property (@(posedge clk) disable iff (rst)
        (issueOneHot & ~slotReady) == '0)
        else $error("issueOneHot selects a slot that is not ready");

    // new branch only lands in an empty slot
    allocIntoEmpty: assert property (@(posedge clk) disable iff (rst)
        (allocOneHot & ~slotEmpty) == '0)
        else $error("allocOneHot selects an occupied slot");

    allocSingle: assert property (@(posedge clk) disable iff (rst)
        $onehot0(allocOneHot))
        else $error("allocOneHot selects more than one slot");

    countBound: assert property (@(posedge clk) disable iff (rst)
        int'(occupiedCount) <= rsSize)
        else $error("occupied count exceeds the station depth");

endmodule

bind branchRsCtrl rsCtrlChecks #(.rsSize(rsSize)) ctrlChecks (
    .clk(clk),
    .rst(rst),
    .slotEmpty(slotEmpty),
    .slotReady(slotReady),
    .allocOneHot(allocOneHot),
    .issueOneHot(issueOneHot),
    .occupiedCount(occupiedCount)
);

`default_nettype wire

/* tests/branchUnitTb.sv */
//##########################################################
// Branch issue path testbench
// LFSR branches checked against a reference table
//##########################################################
`default_nettype none
`timescale 1ns/100ps

module branchUnitTb;

    localparam int depth = rsPkg::defaultRsSize;
    localparam int tw    = rsPkg::tagWidth;

    logic             clk;
    logic             rst;
    logic             dispatchEn;
    isaPkg::branchOp  dispatchOp;
    logic [31:0]      dispatchDataO, dispatchDataT, dispatchImm, dispatchPc;
    logic [tw-1:0]    dispatchTagO, dispatchTagT, dispatchDest;
    logic             aluWrtEn, lsWrtEn;
    logic [tw-1:0]    aluTag, lsTag;
    logic [31:0]      aluData, lsData;
    logic [depth-1:0] freeSlots;
    logic             resultValid, resultTaken;
    logic [tw-1:0]    resultTag;
    logic [31:0]      resultTarget, resultLink;

    // reference table indexed by destination tag
    logic             expTaken  [32];
    logic [31:0]      expTarget [32];
    logic [31:0]      expLink   [32];
    int               sentCnt   [32];
    int               doneCnt   [32];
    int               waitCount [32];
    // operands still owed on a result bus
    logic [tw-1:0]    qTag  [$];
    logic [31:0]      qData [$];
    logic [tw-1:0]    qDest [$];
    logic [31:0]      lfsr;
    logic [tw-1:0]    nextDest, nextOpTag;
    int               dispatched, reported;

    branchUnit UUT (.*);

    always #4 clk = ~clk;

    task automatic mismatch(input string name, input logic [31:0] got, input logic [31:0] exp);
        $display("CHECK FAILED at %0t ns: %s = 0x%h, expected 0x%h", $time, name, got, exp);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic abortRun(input string why);
        $display("Error at %0t ns: %s", $time, why);
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    // Galois LFSR stepped once per bit
    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr[0] ? (lfsr >> 1) ^ 32'h8020_0003 : lfsr >> 1;
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // {taken, target, link}
    function automatic logic [64:0] refBranch(
        input isaPkg::branchOp op,
        input logic [31:0]     a,
        input logic [31:0]     b,
        input logic [31:0]     imm,
        input logic [31:0]     pc
    );
        logic        taken;
        logic [31:0] target;
        target = pc + imm;
        case (op)
            isaPkg::opBeq:  taken = a == b;
            isaPkg::opBne:  taken = a != b;
            isaPkg::opBlt:  taken = $signed(a) < $signed(b);
            isaPkg::opBge:  taken = !($signed(a) < $signed(b));
            isaPkg::opBltu: taken = a < b;
            isaPkg::opBgeu: taken = !(a < b);
            isaPkg::opJal:  taken = 1'b1;
            default: begin
                taken  = 1'b1;
                target = (a + imm) & 32'hffff_fffe;
            end
        endcase
        return {taken, target, pc + 32'd4};
    endfunction

    task automatic idleInputs();
        dispatchEn    = 1'b0;
        dispatchOp    = isaPkg::opNop;
        dispatchDataO = '0;
        dispatchDataT = '0;
        dispatchImm   = '0;
        dispatchPc    = '0;
        dispatchTagO  = rsPkg::tagFree;
        dispatchTagT  = rsPkg::tagFree;
        dispatchDest  = '0;
        aluWrtEn      = 1'b0;
        aluTag        = '0;
        aluData       = '0;
        lsWrtEn       = 1'b0;
        lsTag         = '0;
        lsData        = '0;
    endtask

    task automatic step();
        @(negedge clk);
        idleInputs();
    endtask

    // tag goes out now and the value follows on a bus
    task automatic deferOperand(input logic [31:0] value, output logic [tw-1:0] tag,
                                output logic [31:0] stale);
        tag       = nextOpTag;
        stale     = randBits(32);
        nextOpTag = (nextOpTag == 5'd31) ? 5'd16 : nextOpTag + 5'd1;
        qTag.push_back(tag);
        qData.push_back(value);
        qDest.push_back(nextDest);
    endtask

    task automatic driveDispatch(input isaPkg::branchOp op, input logic waitO,
                                 input logic waitT);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] pc;
        a   = randBits(32);
        b   = randBits(1) != 0 ? a : randBits(32);
        imm = randBits(32);
        pc  = randBits(30) << 2;
        if (op == isaPkg::opJalr) begin
            // odd sum so that bit 0 must be dropped
            imm[0] = ~a[0];
        end
        nextDest = (nextDest == 5'd15) ? 5'd1 : nextDest + 5'd1;
        {expTaken[nextDest], expTarget[nextDest], expLink[nextDest]} =
            refBranch(op, a, b, imm, pc);
        sentCnt[nextDest]   = sentCnt[nextDest] + 1;
        waitCount[nextDest] = int'(waitO) + int'(waitT);
        dispatchEn    = 1'b1;
        dispatchOp    = op;
        dispatchImm   = imm;
        dispatchPc    = pc;
        dispatchDest  = nextDest;
        dispatchDataO = a;
        dispatchDataT = b;
        if (waitO) begin
            deferOperand(a, dispatchTagO, dispatchDataO);
        end
        if (waitT) begin
            deferOperand(b, dispatchTagT, dispatchDataT);
        end
    endtask

    task automatic driveBroadcast(input logic useLs);
        waitCount[qDest[0]] = waitCount[qDest[0]] - 1;
        if (useLs) begin
            lsWrtEn = 1'b1;
            lsTag   = qTag[0];
            lsData  = qData[0];
        end else begin
            aluWrtEn = 1'b1;
            aluTag   = qTag[0];
            aluData  = qData[0];
        end
        void'(qTag.pop_front());
        void'(qData.pop_front());
        void'(qDest.pop_front());
    endtask

    task automatic releaseAll();
        while (qTag.size() != 0) begin
            driveBroadcast(randBits(1) != 0);
            step();
        end
    endtask

    task automatic waitDrained();
        int n;
        n = 0;
        @(posedge clk);
        while (reported != dispatched) begin
            n++;
            if (n > 100) begin
                abortRun("timed out waiting for outstanding branch results");
            end
            @(posedge clk);
        end
        @(negedge clk);
    endtask

    always @(posedge clk) begin
        if (dispatchEn) begin
            dispatched <= dispatched + 1;
        end
    end

    // result and occupancy checks on the falling edge
    always @(negedge clk) begin
        if (!rst) begin
            if (resultValid) begin
                assert (sentCnt[resultTag] == doneCnt[resultTag] + 1)
                    else abortRun("result for a tag with no branch in flight");
                assert (waitCount[resultTag] == 0)
                    else abortRun("result before both operand tags were broadcast");
                assert (resultTaken == expTaken[resultTag])
                    else mismatch("resultTaken", 32'(resultTaken), 32'(expTaken[resultTag]));
                assert (resultTarget == expTarget[resultTag])
                    else mismatch("resultTarget", resultTarget, expTarget[resultTag]);
                assert (resultLink == expLink[resultTag])
                    else mismatch("resultLink", resultLink, expLink[resultTag]);
                doneCnt[resultTag] = doneCnt[resultTag] + 1;
                reported = reported + 1;
            end
            assert ($countones(freeSlots) == depth - (dispatched - reported))
                else mismatch("freeSlots", 32'($countones(freeSlots)),
                              32'(depth - (dispatched - reported)));
        end
    end

    initial begin
        int k;
        int randomSent;
        int leftover;
        clk        = 1'b0;
        rst        = 1'b1;
        lfsr       = 32'h4861_9e97;
        nextDest   = '0;
        nextOpTag  = 5'd16;
        randomSent = 0;
        leftover   = 0;
        idleInputs();
        repeat (8) @(negedge clk);
        rst = 1'b0;
        assert (resultValid == 1'b0) else mismatch("resultValid", 32'(resultValid), 32'd0);
        assert (freeSlots == '1)
            else mismatch("freeSlots", 32'(freeSlots), 32'({depth{1'b1}}));

        // idle station gives a result two edges later
        driveDispatch(isaPkg::opBeq, 1'b0, 1'b0);
        step();
        step();
        assert (resultValid)
            else abortRun("no result two edges after a ready dispatch");
        assert (resultTag == nextDest)
            else mismatch("resultTag", 32'(resultTag), 32'(nextDest));
        waitDrained();

        // operands on the ALU bus and then on the load/store bus
        for (int bus = 0; bus < 2; bus++) begin
            driveDispatch(isaPkg::opBlt, 1'b1, 1'b1);
            step();
            repeat (3) step();
            driveBroadcast(bus != 0);
            step();
            driveBroadcast(bus != 0);
            step();
            waitDrained();
        end

        // broadcast on the dispatch edge
        driveDispatch(isaPkg::opBgeu, 1'b1, 1'b1);
        driveBroadcast(1'b0);
        driveBroadcast(1'b1);
        step();
        waitDrained();

        // fill every slot before releasing operands
        for (int i = 0; i < depth; i++) begin
            driveDispatch(isaPkg::branchOp'(4'(randBits(3) + 1)), 1'b1, randBits(1) != 0);
            step();
        end
        assert (freeSlots == '0) else mismatch("freeSlots", 32'(freeSlots), 32'd0);
        releaseAll();
        waitDrained();

        driveDispatch(isaPkg::opJal, 1'b0, 1'b0);
        step();
        driveDispatch(isaPkg::opJalr, 1'b1, 1'b0);
        step();
        releaseAll();
        waitDrained();

        while (randomSent < 200) begin
            k = 1 + int'(randBits(2)) % depth;
            for (int i = 0; i < k && randomSent < 200; i++) begin
                driveDispatch(isaPkg::branchOp'(4'(randBits(3) + 1)),
                              randBits(1) != 0, randBits(1) != 0);
                if (qTag.size() != 0 && randBits(1) != 0) begin
                    driveBroadcast(randBits(1) != 0);
                end
                step();
                randomSent++;
            end
            releaseAll();
            waitDrained();
        end

        for (int t = 0; t < 32; t++) begin
            if (sentCnt[t] != doneCnt[t]) begin
                leftover++;
            end
        end
        if (leftover == 0 && qTag.size() == 0) begin
            $display("ALL TESTS PASSED");
            $finish;
        end else begin
            $display("SOME TESTS FAILED");
            $fatal(1, "branches left without a result");
        end
    end

endmodule

`default_nettype wire

/* src.f */
source/isaPkg.sv
source/rsPkg.sv
source/branchRsCtrl.sv
source/branchRsEntries.sv
source/branchExec.sv
source/branchUnit.sv
tests/branchUnit_assertions.sv
tests/branchUnitTb.sv

/* runSim.sh */
#!/usr/bin/env bash
# build and run the branch unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f src.f \
    --top-module branchUnitTb \
    -o branchUnitSim

./obj_dir/branchUnitSim
